// ==== all.f ====
mul_op_pkg.sv
mul_fsm_pkg.sv
mul_operand_prep.sv
mul_shift_add_core.sv
mul_result_sel.sv
mul_unit_top.sv
tb_clk_gen.sv
tb_mul_unit.sv

// ==== mul_fsm_pkg.sv ====
// ------------------------------------------------
// State encoding of the iterative multiply core
// Used by the shift-add core, and by the testbench
// for readable state names in messages
// ------------------------------------------------
`default_nettype none

package mul_fsm_pkg;

    // Encoding 2'b11 is unused and falls back to idle
    typedef enum logic [1:0] {
        ST_IDLE = 2'b00, // Waiting for a request
        ST_RUN  = 2'b01, // One multiplier bit per cycle
        ST_DONE = 2'b10  // Product held until taken
    } mul_state_e;

endpackage

`default_nettype wire

// ==== mul_op_pkg.sv ====
// ------------------------------------------------
// Opcode encoding of the RV32M multiply unit
// Decode helpers give operand signedness and the
// product half an opcode returns
// Shared by the RTL and the testbench reference model
// ------------------------------------------------
`default_nettype none

package mul_op_pkg;

    // Same as funct3[1:0] of the multiply instructions
    typedef enum logic [1:0] {
        MUL_LO  = 2'b00, // MUL returns the low word of signed x signed
        MUL_HSS = 2'b01, // MULH returns the high word of signed x signed
        MUL_HSU = 2'b10, // MULHSU returns the high word of signed x unsigned
        MUL_HUU = 2'b11  // MULHU returns the high word of unsigned x unsigned
    } mul_op_e;

    function automatic logic op_a_signed(input mul_op_e op);
        return (op != MUL_HUU); // Only MULHU reads a as unsigned
    endfunction

    function automatic logic op_b_signed(input mul_op_e op);
        return (op == MUL_LO) || (op == MUL_HSS); // b is unsigned for HSU and HUU
    endfunction

    // Low half is sign agnostic so MUL may treat both as signed
    function automatic logic op_high_half(input mul_op_e op);
        return (op != MUL_LO);
    endfunction

endpackage

`default_nettype wire

// ==== mul_operand_prep.sv ====
// ------------------------------------------------
// Operand preparation for the multiply unit
// Strips the sign of each operand so the core works
// on magnitudes only, and flags when the product
// has to be negated again at the output
// Purely combinational, sits in front of the core
// ------------------------------------------------
`default_nettype none

module mul_operand_prep #(
    parameter int XLEN = 32 // Operand width
) (
    input  logic [XLEN-1:0]     a_i,        // Operand a, rs1
    input  logic [XLEN-1:0]     b_i,        // Operand b, rs2
    input  mul_op_pkg::mul_op_e op_i,       // Multiply opcode
    output logic [XLEN-1:0]     mag_a_o,    // Magnitude of a
    output logic [XLEN-1:0]     mag_b_o,    // Magnitude of b
    output logic                neg_prod_o  // Product sign must be restored
);

    logic sign_a;   // a is signed and negative
    logic sign_b;   // b is signed and negative

    // Two's complement magnitude when neg is set
    function automatic logic [XLEN-1:0] magnitude(
        input logic [XLEN-1:0] val,
        input logic            neg
    );
        return neg ? (~val + XLEN'(1)) : val;
    endfunction

    // ------------------------------------------------
    // Effective signs
    // ------------------------------------------------
    assign sign_a = mul_op_pkg::op_a_signed(op_i) & a_i[XLEN-1];   // MSB only counts if signed
    assign sign_b = mul_op_pkg::op_b_signed(op_i) & b_i[XLEN-1];

    // ------------------------------------------------
    // Magnitudes
    // ------------------------------------------------
    // Most negative value maps onto 2^(XLEN-1) which still fits unsigned
    assign mag_a_o = magnitude(a_i, sign_a);
    assign mag_b_o = magnitude(b_i, sign_b);

    assign neg_prod_o = sign_a ^ sign_b;    // Negative iff exactly one operand negative

endmodule

`default_nettype wire

// ==== mul_result_sel.sv ====
// ------------------------------------------------
// Result selection of the multiply unit
// Puts the sign back on the magnitude product and
// returns the low or high word the opcode asks for
// Purely combinational, sits behind the core
// ------------------------------------------------
`default_nettype none

module mul_result_sel #(
    parameter int XLEN = 32 // Operand width
) (
    input  logic [2*XLEN-1:0]   product_i,  // Magnitude product from the core
    input  logic                neg_i,      // Product has to be negated
    input  mul_op_pkg::mul_op_e op_i,       // Opcode captured with the request
    output logic [XLEN-1:0]     result_o    // Word written to rd
);

    localparam int PW = 2 * XLEN;  // Full product width

    logic [PW-1:0]   prod_fix;     // Product with its sign restored
    logic [XLEN-1:0] word_hi;      // Upper half for MULH, MULHSU, MULHU
    logic [XLEN-1:0] word_lo;      // Lower half for MUL

    // ------------------------------------------------
    // Sign restore
    // ------------------------------------------------
    // Negate over the full width so the borrow reaches the high word
    assign prod_fix = neg_i ? (~product_i + PW'(1)) : product_i;

    // ------------------------------------------------
    // Half select
    // ------------------------------------------------
    assign word_hi = prod_fix[PW-1:XLEN];
    assign word_lo = prod_fix[XLEN-1:0];

    assign result_o = mul_op_pkg::op_high_half(op_i) ? word_hi : word_lo;

endmodule

`default_nettype wire

// ==== mul_shift_add_core.sv ====
// ------------------------------------------------
// Iterative shift-and-add multiplier core
// Takes one multiplier bit per cycle, so a product
// is ready XLEN cycles after the request is accepted
// Valid/ready handshake on both sides, one operation
// in flight at a time, result held under back-pressure
// ------------------------------------------------
`default_nettype none

module mul_shift_add_core #(
    parameter int XLEN = 32 // Operand width
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic [XLEN-1:0]     mag_a_i,        // Multiplicand magnitude
    input  logic [XLEN-1:0]     mag_b_i,        // Multiplier magnitude
    input  logic                neg_i,          // Negate flag from operand prep
    input  mul_op_pkg::mul_op_e op_i,           // Opcode of the request
    input  logic                in_valid_i,     // Request valid
    output logic                in_ready_o,     // Core can take a request
    output logic                out_valid_o,    // Product available
    input  logic                out_ready_i,    // Consumer takes the product
    output logic [2*XLEN-1:0]   product_o,      // Unsigned magnitude product
    output logic                neg_o,          // Captured negate flag
    output mul_op_pkg::mul_op_e op_o            // Captured opcode
);

    localparam int CNT_W = $clog2(XLEN + 1);   // Holds XLEN down to 0
    localparam int PW    = 2 * XLEN;           // Product width

    mul_fsm_pkg::mul_state_e state_q;
    mul_fsm_pkg::mul_state_e state_d;

    logic [CNT_W-1:0]    cnt_q;      // Remaining iterations
    logic [PW-1:0]       mcand_q;    // Multiplicand, moves left one bit per step
    logic [XLEN-1:0]     mplier_q;   // Multiplier, LSB is the current bit
    logic [PW-1:0]       acc_q;      // Partial product
    logic                neg_q;
    mul_op_pkg::mul_op_e op_q;

    logic accept;   // Request handshake
    logic take;     // Response handshake
    logic running;  // Iteration in progress

    assign in_ready_o  = (state_q == mul_fsm_pkg::ST_IDLE);
    assign out_valid_o = (state_q == mul_fsm_pkg::ST_DONE);
    assign running     = (state_q == mul_fsm_pkg::ST_RUN);
    assign accept      = in_valid_i && in_ready_o;
    assign take        = out_valid_o && out_ready_i;

    // ------------------------------------------------
    // Control FSM
    // ------------------------------------------------
    always_comb begin
        state_d = state_q;
        unique case (state_q)
            mul_fsm_pkg::ST_IDLE: begin
                if (accept) begin
                    state_d = mul_fsm_pkg::ST_RUN;
                end
            end
            mul_fsm_pkg::ST_RUN: begin
                if (cnt_q == CNT_W'(1)) begin  // Last bit handled this cycle
                    state_d = mul_fsm_pkg::ST_DONE;
                end
            end
            mul_fsm_pkg::ST_DONE: begin
                if (take) begin
                    state_d = mul_fsm_pkg::ST_IDLE;
                end
            end
            default: state_d = mul_fsm_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= mul_fsm_pkg::ST_IDLE;
            cnt_q   <= '0;
        end else begin
            state_q <= state_d;
            if (accept) begin
                cnt_q <= CNT_W'(XLEN);     // One step per multiplier bit
            end else if (running) begin
                cnt_q <= cnt_q - CNT_W'(1);
            end
        end
    end

    // ------------------------------------------------
    // Shift-add datapath
    // ------------------------------------------------
    always_ff @(posedge clk) begin
        if (accept) begin
            mcand_q  <= {{XLEN{1'b0}}, mag_a_i};   // Starts at bit position 0
            mplier_q <= mag_b_i;
            acc_q    <= '0;
            neg_q    <= neg_i;
            op_q     <= op_i;
        end else if (running) begin
            if (mplier_q[0]) begin
                acc_q <= acc_q + mcand_q;          // Add shifted multiplicand
            end
            mcand_q  <= mcand_q << 1;              // Next bit position
            mplier_q <= mplier_q >> 1;
        end
    end

    assign product_o = acc_q;
    assign neg_o     = neg_q;
    assign op_o      = op_q;

    // ------------------------------------------------
    // Assertions
    // ------------------------------------------------
    // Every accepted request starts a full run
    a_accept_idle: assert property (@(posedge clk) disable iff (!rst_n)
        accept |=> (running && cnt_q == CNT_W'(XLEN)));

    // Response and its payload hold until the consumer takes them
    a_out_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (out_valid_o && !out_ready_i) |=>
            out_valid_o && $stable({acc_q, neg_q, op_q}));

    // Run never lasts past the final bit
    a_cnt_run: assert property (@(posedge clk) disable iff (!rst_n)
        running |-> cnt_q != '0);

endmodule

`default_nettype wire

// ==== mul_unit_top.sv ====
// ------------------------------------------------
// Top level of the RV32M multiply unit
// Covers MUL, MULH, MULHSU and MULHU with an iterative
// shift-add core, one bit per cycle
// Request takes a, b and op with valid/ready, and the
// response returns the XLEN-bit result with valid/ready
// ------------------------------------------------
`default_nettype none

module mul_unit_top #(
    parameter int XLEN = 32 // Register width, also works with 16 or 64
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic [XLEN-1:0]     a_i,            // rs1 value
    input  logic [XLEN-1:0]     b_i,            // rs2 value
    input  mul_op_pkg::mul_op_e op_i,           // Multiply opcode
    input  logic                in_valid_i,     // Request valid
    output logic                in_ready_o,     // Unit idle and ready
    output logic [XLEN-1:0]     result_o,       // rd value
    output logic                out_valid_o,    // Result valid
    input  logic                out_ready_i     // Consumer ready
);

    logic [XLEN-1:0]     mag_a;     // Operand magnitudes
    logic [XLEN-1:0]     mag_b;
    logic                neg_prod;  // Sign of the request's product
    logic [2*XLEN-1:0]   product;   // Magnitude product
    logic                neg_q;     // Captured sign
    mul_op_pkg::mul_op_e op_q;      // Captured opcode

    // ------------------------------------------------
    // Operand side
    // ------------------------------------------------
    mul_operand_prep #(
        .XLEN (XLEN)
    ) u_prep (
        .a_i        (a_i),
        .b_i        (b_i),
        .op_i       (op_i),
        .mag_a_o    (mag_a),
        .mag_b_o    (mag_b),
        .neg_prod_o (neg_prod)
    );

    mul_shift_add_core #(
        .XLEN (XLEN)
    ) u_core (
        .clk         (clk),
        .rst_n       (rst_n),
        .mag_a_i     (mag_a),
        .mag_b_i     (mag_b),
        .neg_i       (neg_prod),
        .op_i        (op_i),
        .in_valid_i  (in_valid_i),
        .in_ready_o  (in_ready_o),
        .out_valid_o (out_valid_o),
        .out_ready_i (out_ready_i),
        .product_o   (product),
        .neg_o       (neg_q),
        .op_o        (op_q)
    );

    // ------------------------------------------------
    // Result side
    // ------------------------------------------------
    mul_result_sel #(
        .XLEN (XLEN)
    ) u_sel (
        .product_i (product),
        .neg_i     (neg_q),
        .op_i      (op_q),
        .result_o  (result_o)
    );

endmodule

`default_nettype wire

// ==== tb_clk_gen.sv ====
// ------------------------------------------------
// Testbench clock source for the multiply unit
// Free-running clock, first rising edge after half
// a period, period set by the parameter
// ------------------------------------------------
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD = 40   // Clock period in time units
) (
    output logic clk_o          // Generated clock
);

    initial begin
        clk_o = 1'b0;           // Known level from time zero
    end

    always #(PERIOD / 2) clk_o = ~clk_o;    // Half period per phase

endmodule

`default_nettype wire

// ==== tb_mul_unit.sv ====
// ------------------------------------------------
// Directed testbench of the RV32M multiply unit
// Runs MUL, MULH, MULHSU and MULHU against a 2*XLEN
// reference product, checks handshake timing and
// back-pressure, and prints one closing summary
// ------------------------------------------------
`default_nettype none

module tb_mul_unit;

    localparam int XLEN      = 32;
    localparam int TIMEOUT   = 200;     // Cycles allowed per wait
    localparam int DRIVE_DLY = 2;       // Input skew after the rising edge
    localparam logic [XLEN-1:0] MIN_VAL = {1'b1, {(XLEN-1){1'b0}}};    // Most negative
    localparam logic [XLEN-1:0] ONES    = '1;

    logic                clk;
    logic                rst_n;
    logic [XLEN-1:0]     a_i;
    logic [XLEN-1:0]     b_i;
    mul_op_pkg::mul_op_e op_i;
    logic                in_valid_i;
    logic                in_ready_o;
    logic [XLEN-1:0]     result_o;
    logic                out_valid_o;
    logic                out_ready_i;

    int     mismatch_cnt;
    int     timeout_cnt;
    integer seed;

    tb_clk_gen #(.PERIOD(40)) u_clk (.clk_o(clk));

    mul_unit_top #(.XLEN(XLEN)) DUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .a_i         (a_i),
        .b_i         (b_i),
        .op_i        (op_i),
        .in_valid_i  (in_valid_i),
        .in_ready_o  (in_ready_o),
        .result_o    (result_o),
        .out_valid_o (out_valid_o),
        .out_ready_i (out_ready_i)
    );

    // ------------------------------------------------
    // Helpers
    // ------------------------------------------------
    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DLY;                     // Outputs settled, safe to drive and sample
    endtask

    task automatic check_word(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp,
                              input string what);
        if (got !== exp) begin
            mismatch_cnt++;
            $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            mismatch_cnt++;
            $display("MISMATCH at %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    // Full signed or unsigned product per the opcode table, then half select
    function automatic logic [XLEN-1:0] model_result(input logic [XLEN-1:0] a,
                                                     input logic [XLEN-1:0] b,
                                                     input mul_op_pkg::mul_op_e op);
        logic            a_sgn;
        logic            b_sgn;
        logic [2*XLEN-1:0] ext_a;
        logic [2*XLEN-1:0] ext_b;
        logic [2*XLEN-1:0] prod;
        case (op)
            mul_op_pkg::MUL_LO, mul_op_pkg::MUL_HSS: begin
                a_sgn = 1'b1;
                b_sgn = 1'b1;
            end
            mul_op_pkg::MUL_HSU: begin
                a_sgn = 1'b1;
                b_sgn = 1'b0;
            end
            default: begin
                a_sgn = 1'b0;
                b_sgn = 1'b0;
            end
        endcase
        ext_a = a_sgn ? {{XLEN{a[XLEN-1]}}, a} : {{XLEN{1'b0}}, a};
        ext_b = b_sgn ? {{XLEN{b[XLEN-1]}}, b} : {{XLEN{1'b0}}, b};
        prod  = ext_a * ext_b;          // Modulo 2^(2*XLEN) equals the signed product
        return (op == mul_op_pkg::MUL_LO) ? prod[XLEN-1:0] : prod[2*XLEN-1:XLEN];
    endfunction

    // ------------------------------------------------
    // Handshake tasks
    // ------------------------------------------------
    task automatic wait_ready(output logic ok);
        int cycles;
        mul_fsm_pkg::mul_state_e st;
        cycles = 0;
        while (!in_ready_o && cycles < TIMEOUT) begin
            next_cycle();
            cycles++;
        end
        ok = in_ready_o;
        if (!ok) begin
            timeout_cnt++;
            st = DUT.u_core.state_q;
            $display("ERROR at %0t: in_ready_o did not rise within %0d cycles, core in %s",
                     $time, TIMEOUT, st.name());
        end
    endtask

    task automatic wait_valid(output logic ok);
        int cycles;
        mul_fsm_pkg::mul_state_e st;
        cycles = 0;
        while (!out_valid_o && cycles < TIMEOUT) begin
            next_cycle();
            cycles++;
        end
        ok = out_valid_o;
        if (!ok) begin
            timeout_cnt++;
            st = DUT.u_core.state_q;
            $display("ERROR at %0t: out_valid_o did not rise within %0d cycles, core in %s",
                     $time, TIMEOUT, st.name());
        end
    endtask

    // Caller has seen in_ready_o high, so the next edge accepts
    task automatic send_request(input logic [XLEN-1:0] a, input logic [XLEN-1:0] b,
                                input mul_op_pkg::mul_op_e op);
        a_i        = a;
        b_i        = b;
        op_i       = op;
        in_valid_i = 1'b1;
        next_cycle();                   // Accepting edge
        in_valid_i = 1'b0;
        check_flag(in_ready_o, 1'b0, "in_ready_o after accept");
    endtask

    task automatic take_response();
        out_ready_i = 1'b1;
        next_cycle();                   // Response taken here
        out_ready_i = 1'b0;
        check_flag(out_valid_o, 1'b0, "out_valid_o after response taken");
        check_flag(in_ready_o, 1'b1, "in_ready_o after response taken");
    endtask

    task automatic do_op(input logic [XLEN-1:0] a, input logic [XLEN-1:0] b,
                         input mul_op_pkg::mul_op_e op);
        logic            ok;
        logic [XLEN-1:0] exp;
        exp = model_result(a, b, op);
        wait_ready(ok);
        if (ok) begin
            send_request(a, b, op);
            wait_valid(ok);
            if (ok) begin
                check_word(result_o, exp, $sformatf("%s a=%h b=%h", op.name(), a, b));
                take_response();
            end
        end
    endtask

    // ------------------------------------------------
    // Directed tests
    // ------------------------------------------------
    task automatic test_reset_latency();
        check_flag(in_ready_o, 1'b1, "in_ready_o after reset");
        check_flag(out_valid_o, 1'b0, "out_valid_o after reset");
        send_request(XLEN'(5), XLEN'(7), mul_op_pkg::MUL_LO);
        for (int k = 0; k < XLEN; k++) begin   // Latency is fixed at XLEN cycles
            check_flag(out_valid_o, 1'b0, $sformatf("out_valid_o %0d cycles after accept", k));
            next_cycle();
        end
        check_flag(out_valid_o, 1'b1, "out_valid_o XLEN cycles after accept");
        check_word(result_o, XLEN'(35), "MUL_LO 5 x 7");
        take_response();
    endtask

    task automatic test_mul_lo();
        do_op('0, '0, mul_op_pkg::MUL_LO);
        do_op('0, XLEN'(12345), mul_op_pkg::MUL_LO);
        do_op(XLEN'(1), XLEN'(1), mul_op_pkg::MUL_LO);
        do_op(ONES, ONES, mul_op_pkg::MUL_LO);
        do_op(XLEN'(-7), XLEN'(9), mul_op_pkg::MUL_LO);
        do_op(XLEN'(123456), XLEN'(-3), mul_op_pkg::MUL_LO);
        do_op(MIN_VAL, ONES, mul_op_pkg::MUL_LO);   // Wraps back to MIN_VAL
        do_op(~MIN_VAL, XLEN'(2), mul_op_pkg::MUL_LO);
    endtask

    task automatic test_mul_high_signed();
        do_op(ONES, ONES, mul_op_pkg::MUL_HSS);
        do_op(XLEN'(-7), XLEN'(9), mul_op_pkg::MUL_HSS);
        do_op(MIN_VAL, MIN_VAL, mul_op_pkg::MUL_HSS);
        do_op(MIN_VAL, ONES, mul_op_pkg::MUL_HSS);
        do_op(MIN_VAL, ~MIN_VAL, mul_op_pkg::MUL_HSS);
        do_op(ONES, ONES, mul_op_pkg::MUL_HSU);     // -1 times 2^XLEN-1
        do_op(MIN_VAL, ONES, mul_op_pkg::MUL_HSU);
        do_op(MIN_VAL, MIN_VAL, mul_op_pkg::MUL_HSU);
        do_op(XLEN'(-5), XLEN'(3), mul_op_pkg::MUL_HSU);
        do_op(XLEN'(12345), ONES, mul_op_pkg::MUL_HSU);
    endtask

    task automatic test_mul_huu();
        logic [XLEN-1:0] ra;
        logic [XLEN-1:0] rb;
        do_op(ONES, ONES, mul_op_pkg::MUL_HUU);
        for (int i = 0; i < 64; i++) begin
            ra = $random(seed);
            rb = $random(seed);
            do_op(ra, rb, mul_op_pkg::MUL_HUU);
        end
    endtask

    task automatic test_backpressure();
        logic            ok;
        logic [XLEN-1:0] held;
        wait_ready(ok);
        if (ok) begin
            send_request(XLEN'(-12345), XLEN'(678), mul_op_pkg::MUL_HSS);
            wait_valid(ok);
            if (ok) begin
                held = result_o;
                check_word(held, model_result(XLEN'(-12345), XLEN'(678),
                           mul_op_pkg::MUL_HSS), "MUL_HSS under back-pressure");
                for (int i = 0; i < 10; i++) begin   // Consumer stalls 10 cycles
                    next_cycle();
                    check_flag(out_valid_o, 1'b1, "out_valid_o held while stalled");
                    check_word(result_o, held, "result_o held while stalled");
                    check_flag(in_ready_o, 1'b0, "in_ready_o while stalled");
                end
                take_response();
            end
        end
        do_op(XLEN'(-99), XLEN'(-101), mul_op_pkg::MUL_LO);   // Follow-up request
    endtask

    // ------------------------------------------------
    // Main sequence
    // ------------------------------------------------
    initial begin
        seed         = 32'ha;
        mismatch_cnt = 0;
        timeout_cnt  = 0;
        rst_n        = 1'b0;
        a_i          = '0;
        b_i          = '0;
        op_i         = mul_op_pkg::MUL_LO;
        in_valid_i   = 1'b0;
        out_ready_i  = 1'b0;
        repeat (16) @(posedge clk);     // Reset held 16 cycles
        #DRIVE_DLY;
        rst_n = 1'b1;

        test_reset_latency();
        test_mul_lo();
        test_mul_high_signed();
        test_mul_huu();
        test_backpressure();

        $display("Errors: %0d mismatches, %0d timeouts", mismatch_cnt, timeout_cnt);
        if (mismatch_cnt == 0 && timeout_cnt == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
